/* Bender.yml */
package:
  name: apb_mmio_ctrl

sources:
  # Control block RTL, package first
  - files:
      - verilog/mmio_pkg.sv
      - verilog/reg_access_if.sv
      - verilog/apb_mmio_fsm.sv
      - verilog/run_timer.sv
      - verilog/mmio_register_bank.sv
      - verilog/mmio_top.sv

  # Simulation only
  - target: test
    files:
      - test/mmio_properties.sv
      - test/tb_mmio.sv

/* tb.f */
verilog/mmio_pkg.sv
verilog/reg_access_if.sv
verilog/apb_mmio_fsm.sv
verilog/run_timer.sv
verilog/mmio_register_bank.sv
verilog/mmio_top.sv
test/mmio_properties.sv
test/tb_mmio.sv

/* test/mmio_properties.sv */
/* APB response timing, pulse width and read parity assertions.
   Bound to the control block top level by the testbench. */
`timescale 1ns/1ns
`default_nettype none

module mmio_properties (
  input wire                  clock,
  input wire                  rstn,
  input wire                  psel,
  input wire                  penable,
  input wire                  pready,
  input wire mmio_pkg::word_t prdata,
  input wire                  prdata_parity,
  input wire mmio_pkg::word_t algorithm_requests,
  input wire                  report_algorithm_status_ack,
  input wire                  report_errors_ack
);

  logic access_phase;

  // Failed properties so far, polled by the testbench
  int unsigned fail_count = 0;

  assign access_phase = psel && penable;

  //////////////////////////////
  // Bus response
  //////////////////////////////
  // Two wait states, then one response cycle
  pready_timing: assert property (@(posedge clock) disable iff (!rstn)
    $rose(access_phase) |-> !pready ##1 !pready ##1 pready ##1 !pready)
    else begin
      fail_count++;
      $error("pready not a single cycle two cycles after the access began");
    end

  read_parity: assert property (@(posedge clock) disable iff (!rstn)
    pready |-> (^{prdata, prdata_parity}) == 1'b1)
    else begin
      fail_count++;
      $error("prdata_parity does not give odd parity over prdata");
    end

  //////////////////////////////
  // Engine pulses
  //////////////////////////////
  request_pulse: assert property (@(posedge clock) disable iff (!rstn)
    (algorithm_requests != '0) |-> pready ##1 (algorithm_requests == '0))
    else begin
      fail_count++;
      $error("algorithm_requests held longer than the response cycle");
    end

  status_ack_pulse: assert property (@(posedge clock) disable iff (!rstn)
    report_algorithm_status_ack |-> pready ##1 !report_algorithm_status_ack)
    else begin
      fail_count++;
      $error("report_algorithm_status_ack is not a one cycle pulse");
    end

  errors_ack_pulse: assert property (@(posedge clock) disable iff (!rstn)
    report_errors_ack |-> pready ##1 !report_errors_ack)
    else begin
      fail_count++;
      $error("report_errors_ack is not a one cycle pulse");
    end

endmodule

`default_nettype wire

/* test/tb_mmio.sv */
/* Testbench for the APB control block: random register traffic from an LFSR,
   checked against a register, sticky error and timer model kept here. */
`timescale 1ns/1ns
`default_nettype none

module tb_mmio;

  localparam int N_TRANS     = 400;
  // About 6 cycles per access plus timer runs, with margin
  localparam int CYCLE_LIMIT = N_TRANS * 10;

  logic                 clock;
  logic                 rstn;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  mmio_pkg::mmio_addr_t paddr;
  logic                 paddr_parity;
  mmio_pkg::word_t      pwdata;
  logic                 pwdata_parity;
  mmio_pkg::word_t      prdata;
  logic                 prdata_parity;
  logic                 pready;
  logic                 pslverr;
  mmio_pkg::word_t      algorithm_status;
  mmio_pkg::word_t      algorithm_status_done;
  mmio_pkg::word_t      report_errors;
  mmio_pkg::word_t      afu_status;
  mmio_pkg::word_t      algorithm_running;
  mmio_pkg::word_t      algorithm_requests;
  logic                 report_algorithm_status_ack;
  logic                 report_errors_ack;
  mmio_pkg::err_bits_t  mmio_errors;

  // Model state
  logic [31:0]          lfsr;
  mmio_pkg::err_bits_t  sticky;
  logic                 restart_req;
  logic [1:0]           phase;
  mmio_pkg::word_t      run_d;
  mmio_pkg::cycles_t    model_cycles;
  mmio_pkg::cycles_t    cycles_at_read;
  int unsigned          cycle_count;

  mmio_top DUT (.*);

  bind mmio_top mmio_properties u_props (
    .clock                       (clock),
    .rstn                        (rstn),
    .psel                        (psel),
    .penable                     (penable),
    .pready                      (pready),
    .prdata                      (prdata),
    .prdata_parity               (prdata_parity),
    .algorithm_requests          (algorithm_requests),
    .report_algorithm_status_ack (report_algorithm_status_ack),
    .report_errors_ack           (report_errors_ack)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  //////////////////////////////
  // Random numbers and reference rules
  //////////////////////////////
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[62:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic rare_event(input int n);
    return rand_bits(n) == 64'd0;
  endfunction

  function automatic logic odd_parity_bit(input logic [63:0] v);
    return ~(^v);
  endfunction

  function automatic logic access_allowed(input mmio_pkg::mmio_addr_t a, input logic wr);
    case ({a[11:3], 3'b000})
      mmio_pkg::ALGO_REQUEST,
      mmio_pkg::ALGO_STATUS_DONE_ACK,
      mmio_pkg::ERROR_REG_ACK:    return wr;
      mmio_pkg::MMIO_ERRORS:      return 1'b1;
      mmio_pkg::DESC_0,
      mmio_pkg::DESC_1,
      mmio_pkg::ALGO_STATUS,
      mmio_pkg::ALGO_STATUS_DONE,
      mmio_pkg::ERROR_REG,
      mmio_pkg::AFU_STATUS,
      mmio_pkg::ALGO_RUNNING,
      mmio_pkg::RUN_CYCLES:       return !wr;
      default:                    return 1'b0;
    endcase
  endfunction

  function automatic mmio_pkg::word_t expected_read(input mmio_pkg::mmio_addr_t a);
    case ({a[11:3], 3'b000})
      mmio_pkg::DESC_0:           return mmio_pkg::DESC_0_VALUE;
      mmio_pkg::DESC_1:           return mmio_pkg::DESC_1_VALUE;
      mmio_pkg::ALGO_STATUS:      return algorithm_status;
      mmio_pkg::ALGO_STATUS_DONE: return algorithm_status_done;
      mmio_pkg::ERROR_REG:        return report_errors;
      mmio_pkg::AFU_STATUS:       return afu_status;
      mmio_pkg::ALGO_RUNNING:     return algorithm_running;
      mmio_pkg::RUN_CYCLES:       return {32'd0, cycles_at_read};
      mmio_pkg::MMIO_ERRORS:      return {62'd0, sticky};
      default:                    return 64'd0;
    endcase
  endfunction

  //////////////////////////////
  // Timer model, tracks the bus phase of each access
  //////////////////////////////
  always @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      phase          <= 2'd0;
      run_d          <= '0;
      model_cycles   <= '0;
      cycles_at_read <= '0;
    end else begin
      run_d <= algorithm_running;
      case (phase)
        2'd0: if (psel && penable) phase <= 2'd1;
        2'd1: begin
          phase          <= 2'd2;
          cycles_at_read <= model_cycles;
        end
        default: phase <= 2'd0;
      endcase
      if ((phase == 2'd1) && restart_req) begin
        model_cycles <= '0;
      end else if ((run_d != '0) && (model_cycles != '1)) begin
        model_cycles <= model_cycles + 32'd1;
      end
    end
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("Timeout after %0d cycles, the test sequence never finished", CYCLE_LIMIT);
    $display("Test failures found");
    $fatal(1, "Run stopped by the cycle limit");
  end

  // Stop at the first failed bus or pulse property
  always @(negedge clock) begin
    if (DUT.u_props.fail_count != 0) begin
      $display("A bound property on the bus or pulse outputs failed");
      $display("Test failures found");
      $fatal(1, "Stopping at the first property failure");
    end
  end

  //////////////////////////////
  // Checks and bus tasks
  //////////////////////////////
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
      $display("Test failures found");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Outside the response cycle nothing may pulse
  task automatic check_quiet();
    check_value("algorithm_requests", algorithm_requests, 64'd0);
    check_value("report_algorithm_status_ack", 64'(report_algorithm_status_ack), 64'd0);
    check_value("report_errors_ack", 64'(report_errors_ack), 64'd0);
    check_value("pready", 64'(pready), 64'd0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clock);
      check_quiet();
    end
  endtask

  task automatic run_access(input logic wr, input mmio_pkg::mmio_addr_t a,
                            input mmio_pkg::word_t d, input logic bad_addr,
                            input logic bad_data);
    mmio_pkg::mmio_addr_t wa;
    mmio_pkg::word_t      exp_rdata;
    mmio_pkg::word_t      exp_req;
    mmio_pkg::err_bits_t  exp_sticky;
    logic                 refused;
    logic                 clean_write;
    int                   waits;
    wa          = {a[11:3], 3'b000};
    refused     = bad_addr || (wr && bad_data) || !access_allowed(a, wr);
    clean_write = !refused && wr;
    exp_sticky  = sticky;
    if (clean_write && (wa == mmio_pkg::MMIO_ERRORS)) exp_sticky = exp_sticky & ~d[1:0];
    if (bad_addr) exp_sticky[0] = 1'b1;
    if (wr && bad_data) exp_sticky[1] = 1'b1;
    exp_req = (clean_write && (wa == mmio_pkg::ALGO_REQUEST)) ? d : 64'd0;
    // Setup phase, then the access phase
    @(posedge clock);
    psel          <= 1'b1;
    penable       <= 1'b0;
    pwrite        <= wr;
    paddr         <= a;
    paddr_parity  <= odd_parity_bit(64'(a)) ^ bad_addr;
    pwdata        <= d;
    pwdata_parity <= odd_parity_bit(d) ^ (wr && bad_data);
    restart_req   <= clean_write && (wa == mmio_pkg::ALGO_REQUEST) && (|d);
    @(posedge clock);
    penable <= 1'b1;
    waits = 0;
    @(negedge clock);
    while (!pready) begin
      check_quiet();
      waits++;
      @(negedge clock);
    end
    exp_rdata = (!refused && !wr) ? expected_read(a) : 64'd0;
    check_value("wait_states", 64'(waits), 64'd2);
    check_value("pslverr", 64'(pslverr), 64'(refused));
    check_value("prdata", prdata, exp_rdata);
    check_value("prdata_parity", 64'(prdata_parity), 64'(odd_parity_bit(exp_rdata)));
    check_value("algorithm_requests", algorithm_requests, exp_req);
    check_value("report_algorithm_status_ack", 64'(report_algorithm_status_ack),
                64'(clean_write && (wa == mmio_pkg::ALGO_STATUS_DONE_ACK) && (|d)));
    check_value("report_errors_ack", 64'(report_errors_ack),
                64'(clean_write && (wa == mmio_pkg::ERROR_REG_ACK) && (|d)));
    check_value("mmio_errors", 64'(mmio_errors), 64'(exp_sticky));
    sticky = exp_sticky;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic change_status();
    algorithm_status      <= rand_bits(64);
    algorithm_status_done <= rand_bits(64);
    report_errors         <= rand_bits(64);
    afu_status            <= rand_bits(64);
    algorithm_running     <= rare_event(1) ? rand_bits(64) : 64'd0;
  endtask

  task automatic random_access();
    logic                 wr;
    logic [3:0]           pick;
    mmio_pkg::mmio_addr_t a;
    mmio_pkg::word_t      d;
    logic                 bad_addr;
    logic                 bad_data;
    wr   = 1'(rand_bits(1));
    pick = 4'(rand_bits(4));
    // Mostly mapped words with random byte offsets
    if (pick < 4'd12) a = {5'd0, pick, 3'(rand_bits(3))};
    else a = 12'(rand_bits(12));
    if (rare_event(3)) d = 64'd0;
    else d = rand_bits(64);
    bad_addr = rare_event(3);
    bad_data = wr && rare_event(3);
    run_access(wr, a, d, bad_addr, bad_data);
  endtask

  // Request, let the engine run a while, then read the timer
  task automatic timer_run();
    mmio_pkg::word_t req;
    req = rand_bits(64) | 64'd1;
    run_access(1'b1, mmio_pkg::ALGO_REQUEST, req, 1'b0, 1'b0);
    @(posedge clock);
    algorithm_running <= rand_bits(64) | 64'h100;
    idle_cycles(1 + int'(rand_bits(3)));
    run_access(1'b0, mmio_pkg::RUN_CYCLES, 64'd0, 1'b0, 1'b0);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    int t;
    lfsr                  = 32'h04b0_04ad;
    sticky                = '0;
    restart_req           = 1'b0;
    cycle_count           = 0;
    rstn                  = 1'b0;
    psel                  = 1'b0;
    penable               = 1'b0;
    pwrite                = 1'b0;
    paddr                 = '0;
    paddr_parity          = 1'b1;
    pwdata                = '0;
    pwdata_parity         = 1'b1;
    algorithm_status      = '0;
    algorithm_status_done = '0;
    report_errors         = '0;
    afu_status            = '0;
    algorithm_running     = '0;

    repeat (3) @(posedge clock);
    @(negedge clock);
    check_quiet();
    check_value("pslverr", 64'(pslverr), 64'd0);
    check_value("prdata", prdata, 64'd0);
    check_value("prdata_parity", 64'(prdata_parity), 64'd1);
    check_value("mmio_errors", 64'(mmio_errors), 64'd0);
    repeat (5) @(posedge clock);
    rstn <= 1'b1;
    idle_cycles(2);

    run_access(1'b0, mmio_pkg::DESC_0, 64'd0, 1'b0, 1'b0);
    run_access(1'b0, mmio_pkg::DESC_1, 64'd0, 1'b0, 1'b0);

    for (t = 0; t < N_TRANS; t++) begin
      idle_cycles(1);
      @(posedge clock);
      if (rare_event(2)) change_status();
      idle_cycles(1 + int'(rand_bits(1)));
      if (rare_event(4)) timer_run();
      else random_access();
    end

    // Clear both sticky bits and read back
    idle_cycles(1);
    run_access(1'b1, mmio_pkg::MMIO_ERRORS, 64'h3, 1'b0, 1'b0);
    run_access(1'b0, mmio_pkg::MMIO_ERRORS, 64'd0, 1'b0, 1'b0);
    idle_cycles(2);
    if (DUT.u_props.fail_count != 0) begin
      $display("A bound property failed before the end of the run");
      $display("Test failures found");
      $fatal(1, "Property failures at the end of the run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* verilog/apb_mmio_fsm.sv */
/* APB responder with odd parity checks on address and write data.
   Every access takes two wait states; refused accesses end with pslverr. */
`timescale 1ns/1ns
`default_nettype none

module apb_mmio_fsm (
  input  wire                        clock,
  input  wire                        rstn,
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire  mmio_pkg::mmio_addr_t paddr,
  input  wire                        paddr_parity,
  input  wire  mmio_pkg::word_t      pwdata,
  input  wire                        pwdata_parity,
  output mmio_pkg::word_t            prdata,
  output logic                       prdata_parity,
  output logic                       pready,
  output logic                       pslverr,
  reg_access_if.fsm                  regs
);

  mmio_pkg::fsm_state_t state;

  mmio_pkg::mmio_addr_t addr_q;
  mmio_pkg::word_t      wdata_q;
  logic                 write_q;
  logic                 addr_ok;
  logic                 data_ok;
  logic                 refused;
  logic                 access_ok;
  logic                 access_start;

  assign access_start = (state == mmio_pkg::ST_IDLE) && psel && penable;
  assign access_ok    = addr_ok && data_ok && regs.addr_hit;

  //////////////////////////////
  // State and check results
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state   <= mmio_pkg::ST_IDLE;
      write_q <= 1'b0;
      addr_ok <= 1'b1;
      data_ok <= 1'b1;
      refused <= 1'b0;
    end else begin
      case (state)
        mmio_pkg::ST_IDLE: begin
          if (access_start) begin
            write_q <= pwrite;
            addr_ok <= (paddr_parity == mmio_pkg::odd_parity(mmio_pkg::word_t'(paddr)));
            // Read data lines carry nothing, so only writes are checked
            data_ok <= !pwrite || (pwdata_parity == mmio_pkg::odd_parity(pwdata));
            state   <= mmio_pkg::ST_CHECK;
          end
        end
        mmio_pkg::ST_CHECK: begin
          refused <= !access_ok;
          state   <= mmio_pkg::ST_RESPOND;
        end
        default: begin
          state <= mmio_pkg::ST_IDLE;
        end
      endcase
    end
  end

  // Address and data captured in the first access cycle
  always_ff @(posedge clock) begin
    if (access_start) begin
      addr_q  <= paddr;
      wdata_q <= pwdata;
    end
  end

  //////////////////////////////
  // Bank strobes
  //////////////////////////////
  assign regs.addr     = addr_q;
  assign regs.wdata    = wdata_q;
  assign regs.write    = write_q;
  assign regs.read_en  = (state == mmio_pkg::ST_CHECK) && access_ok && !write_q;
  assign regs.write_en = (state == mmio_pkg::ST_CHECK) && access_ok && write_q;

  // Failed parities become sticky error requests
  always_comb begin
    regs.err_set = '0;
    if (state == mmio_pkg::ST_CHECK) begin
      regs.err_set[mmio_pkg::ERR_ADDR_BIT] = !addr_ok;
      regs.err_set[mmio_pkg::ERR_DATA_BIT] = !data_ok;
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////
  assign pready        = (state == mmio_pkg::ST_RESPOND);
  assign pslverr       = pready && refused;
  assign prdata        = (pready && !refused && !write_q) ? regs.rdata : '0;
  assign prdata_parity = mmio_pkg::odd_parity(prdata);

endmodule

`default_nettype wire

/* verilog/mmio_pkg.sv */
/* Register map, widths, descriptor constants and helpers for the APB control block.
   RTL files refer to these by scoped name. */
`default_nettype none

package mmio_pkg;

  //////////////////////////////
  // Widths fixed by the register map
  //////////////////////////////
  localparam int WORD_W   = 64;
  localparam int ADDR_W   = 12;
  localparam int ERR_W    = 2;
  localparam int CYCLES_W = 32;

  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [ADDR_W-1:0]   mmio_addr_t;
  typedef logic [ERR_W-1:0]    err_bits_t;
  typedef logic [CYCLES_W-1:0] cycles_t;

  // Sticky error bit positions
  localparam int ERR_ADDR_BIT = 0;
  localparam int ERR_DATA_BIT = 1;

  // Bus responder states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CHECK,
    ST_RESPOND
  } fsm_state_t;

  //////////////////////////////
  // Register addresses, 8-byte aligned
  //////////////////////////////
  localparam mmio_addr_t DESC_0               = 12'h000;
  localparam mmio_addr_t DESC_1               = 12'h008;
  localparam mmio_addr_t ALGO_REQUEST         = 12'h010;
  localparam mmio_addr_t ALGO_STATUS          = 12'h018;
  localparam mmio_addr_t ALGO_STATUS_DONE     = 12'h020;
  localparam mmio_addr_t ALGO_STATUS_DONE_ACK = 12'h028;
  localparam mmio_addr_t ERROR_REG            = 12'h030;
  localparam mmio_addr_t ERROR_REG_ACK        = 12'h038;
  localparam mmio_addr_t AFU_STATUS           = 12'h040;
  localparam mmio_addr_t ALGO_RUNNING         = 12'h048;
  localparam mmio_addr_t RUN_CYCLES           = 12'h050;
  localparam mmio_addr_t MMIO_ERRORS          = 12'h058;

  //////////////////////////////
  // Accelerator descriptor words
  //////////////////////////////
  // Interrupts per process, process count, config records, programming model
  localparam word_t DESC_0_VALUE = 64'h0000_0001_0001_8010;
  // Config record length and offset of the single record
  localparam word_t DESC_1_VALUE = 64'h0000_0001_0000_0100;

  // Bit that makes the ones count of data plus this bit odd
  function automatic logic odd_parity(input word_t data);
    return ~(^data);
  endfunction

endpackage

`default_nettype wire

/* verilog/mmio_register_bank.sv */
/* Register bank behind the APB responder: latched engine status, descriptor table,
   write pulses toward the engine and the sticky parity error register. */
`timescale 1ns/1ns
`default_nettype none

module mmio_register_bank (
  input  wire                     clock,
  input  wire                     rstn,
  input  wire  mmio_pkg::word_t   algorithm_status,
  input  wire  mmio_pkg::word_t   algorithm_status_done,
  input  wire  mmio_pkg::word_t   report_errors,
  input  wire  mmio_pkg::word_t   afu_status,
  input  wire  mmio_pkg::word_t   algorithm_running,
  input  wire  mmio_pkg::cycles_t run_cycles,
  output mmio_pkg::word_t         algorithm_requests,
  output logic                    report_algorithm_status_ack,
  output logic                    report_errors_ack,
  output mmio_pkg::err_bits_t     mmio_errors,
  output logic                    timer_restart,
  output mmio_pkg::word_t         running_latched,
  reg_access_if.bank              regs
);

  mmio_pkg::word_t      status_latched;
  mmio_pkg::word_t      status_done_latched;
  mmio_pkg::word_t      errors_latched;
  mmio_pkg::word_t      afu_status_latched;
  mmio_pkg::mmio_addr_t reg_addr;
  mmio_pkg::err_bits_t  err_clr;

  // Byte offset within a word plays no part in decode
  assign reg_addr = {regs.addr[mmio_pkg::ADDR_W-1:3], 3'b000};

  //////////////////////////////
  // Engine status latches
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      status_latched      <= '0;
      status_done_latched <= '0;
      errors_latched      <= '0;
      afu_status_latched  <= '0;
      running_latched     <= '0;
    end else begin
      status_latched      <= algorithm_status;
      status_done_latched <= algorithm_status_done;
      errors_latched      <= report_errors;
      afu_status_latched  <= afu_status;
      running_latched     <= algorithm_running;
    end
  end

  //////////////////////////////
  // Address decode
  //////////////////////////////
  always_comb begin
    case (reg_addr)
      // Pulse registers take writes only
      mmio_pkg::ALGO_REQUEST,
      mmio_pkg::ALGO_STATUS_DONE_ACK,
      mmio_pkg::ERROR_REG_ACK:   regs.addr_hit = regs.write;
      mmio_pkg::MMIO_ERRORS:     regs.addr_hit = 1'b1;
      mmio_pkg::DESC_0,
      mmio_pkg::DESC_1,
      mmio_pkg::ALGO_STATUS,
      mmio_pkg::ALGO_STATUS_DONE,
      mmio_pkg::ERROR_REG,
      mmio_pkg::AFU_STATUS,
      mmio_pkg::ALGO_RUNNING,
      mmio_pkg::RUN_CYCLES:      regs.addr_hit = !regs.write;
      default:                   regs.addr_hit = 1'b0;
    endcase
  end

  // Read data, held for the response cycle
  always_ff @(posedge clock) begin
    if (regs.read_en) begin
      case (reg_addr)
        mmio_pkg::DESC_0:           regs.rdata <= mmio_pkg::DESC_0_VALUE;
        mmio_pkg::DESC_1:           regs.rdata <= mmio_pkg::DESC_1_VALUE;
        mmio_pkg::ALGO_STATUS:      regs.rdata <= status_latched;
        mmio_pkg::ALGO_STATUS_DONE: regs.rdata <= status_done_latched;
        mmio_pkg::ERROR_REG:        regs.rdata <= errors_latched;
        mmio_pkg::AFU_STATUS:       regs.rdata <= afu_status_latched;
        mmio_pkg::ALGO_RUNNING:     regs.rdata <= running_latched;
        mmio_pkg::RUN_CYCLES:       regs.rdata <= mmio_pkg::word_t'(run_cycles);
        mmio_pkg::MMIO_ERRORS:      regs.rdata <= mmio_pkg::word_t'(mmio_errors);
        default:                    regs.rdata <= '0;
      endcase
    end
  end

  //////////////////////////////
  // Write pulses toward the engine
  //////////////////////////////
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      algorithm_requests          <= '0;
      report_algorithm_status_ack <= 1'b0;
      report_errors_ack           <= 1'b0;
    end else begin
      algorithm_requests          <= '0;
      report_algorithm_status_ack <= 1'b0;
      report_errors_ack           <= 1'b0;
      if (regs.write_en) begin
        case (reg_addr)
          mmio_pkg::ALGO_REQUEST:         algorithm_requests <= regs.wdata;
          mmio_pkg::ALGO_STATUS_DONE_ACK: report_algorithm_status_ack <= |regs.wdata;
          mmio_pkg::ERROR_REG_ACK:        report_errors_ack <= |regs.wdata;
          default: ;
        endcase
      end
    end
  end

  // New nonzero request restarts the run timer
  assign timer_restart = regs.write_en && (reg_addr == mmio_pkg::ALGO_REQUEST) && (|regs.wdata);

  //////////////////////////////
  // Sticky parity errors
  //////////////////////////////
  assign err_clr = (regs.write_en && (reg_addr == mmio_pkg::MMIO_ERRORS)) ?
                   regs.wdata[mmio_pkg::ERR_W-1:0] : '0;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      mmio_errors <= '0;
    end else begin
      // A new error in the same cycle survives the clear
      mmio_errors <= (mmio_errors & ~err_clr) | regs.err_set;
    end
  end

endmodule

`default_nettype wire

/* verilog/mmio_top.sv */
/* Control block top level with plain APB and engine ports.
   Joins the bus responder, the register bank and the run timer. */
`timescale 1ns/1ns
`default_nettype none

module mmio_top (
  input  wire                        clock,
  input  wire                        rstn,
  // APB responder
  input  wire                        psel,
  input  wire                        penable,
  input  wire                        pwrite,
  input  wire  mmio_pkg::mmio_addr_t paddr,
  input  wire                        paddr_parity,
  input  wire  mmio_pkg::word_t      pwdata,
  input  wire                        pwdata_parity,
  output mmio_pkg::word_t            prdata,
  output logic                       prdata_parity,
  output logic                       pready,
  output logic                       pslverr,
  // Engine status
  input  wire  mmio_pkg::word_t      algorithm_status,
  input  wire  mmio_pkg::word_t      algorithm_status_done,
  input  wire  mmio_pkg::word_t      report_errors,
  input  wire  mmio_pkg::word_t      afu_status,
  input  wire  mmio_pkg::word_t      algorithm_running,
  // Engine requests and acks
  output mmio_pkg::word_t            algorithm_requests,
  output logic                       report_algorithm_status_ack,
  output logic                       report_errors_ack,
  output mmio_pkg::err_bits_t        mmio_errors
);

  wire mmio_pkg::cycles_t run_cycles;
  wire mmio_pkg::word_t   running_latched;
  wire                    timer_restart;

  reg_access_if regs ();

  apb_mmio_fsm u_fsm (
    .clock         (clock),
    .rstn          (rstn),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .paddr_parity  (paddr_parity),
    .pwdata        (pwdata),
    .pwdata_parity (pwdata_parity),
    .prdata        (prdata),
    .prdata_parity (prdata_parity),
    .pready        (pready),
    .pslverr       (pslverr),
    .regs          (regs.fsm)
  );

  mmio_register_bank u_bank (
    .clock                       (clock),
    .rstn                        (rstn),
    .algorithm_status            (algorithm_status),
    .algorithm_status_done       (algorithm_status_done),
    .report_errors               (report_errors),
    .afu_status                  (afu_status),
    .algorithm_running           (algorithm_running),
    .run_cycles                  (run_cycles),
    .algorithm_requests          (algorithm_requests),
    .report_algorithm_status_ack (report_algorithm_status_ack),
    .report_errors_ack           (report_errors_ack),
    .mmio_errors                 (mmio_errors),
    .timer_restart               (timer_restart),
    .running_latched             (running_latched),
    .regs                        (regs.bank)
  );

  run_timer u_timer (
    .clock   (clock),
    .rstn    (rstn),
    .restart (timer_restart),
    .running (running_latched),
    .count   (run_cycles)
  );

endmodule

`default_nettype wire

/* verilog/reg_access_if.sv */
/* Register access path between the APB responder and the register bank.
   Strobes and address come from the responder; data and decode come back. */
`timescale 1ns/1ns
`default_nettype none

interface reg_access_if;

  // Responder side
  logic                   read_en;
  logic                   write_en;
  logic                   write;
  mmio_pkg::mmio_addr_t   addr;
  mmio_pkg::word_t        wdata;
  mmio_pkg::err_bits_t    err_set;

  // Bank side
  mmio_pkg::word_t        rdata;
  logic                   addr_hit;

  modport fsm (
    output read_en, write_en, write, addr, wdata, err_set,
    input  rdata, addr_hit
  );

  modport bank (
    input  read_en, write_en, write, addr, wdata, err_set,
    output rdata, addr_hit
  );

endinterface

`default_nettype wire

/* verilog/run_timer.sv */
/* Saturating count of cycles in which the engine reports running.
   A restart pulse from a new request clears it. */
`timescale 1ns/1ns
`default_nettype none

module run_timer (
  input  wire                   clock,
  input  wire                   rstn,
  input  wire                   restart,
  input  wire  mmio_pkg::word_t running,
  output mmio_pkg::cycles_t     count
);

  logic at_max;

  assign at_max = (count == '1);

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      count <= '0;
    end else if (restart) begin
      count <= '0;
    end else if ((|running) && !at_max) begin
      // Holds at all ones once full
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire
